/* rtl/la_isa_pkg.sv */
`default_nettype none

package la_isa_pkg;
    localparam int uop_w = 8;

    // bit positions in the one-hot micro-op type
    localparam int uop_csr   = 0;
    localparam int uop_cache = 1;
    localparam int uop_ertn  = 2;
    localparam int uop_idle  = 3;
    localparam int uop_tlb   = 4;

    localparam logic [13:0] csr_crmd  = 14'h000;
    localparam logic [13:0] csr_prmd  = 14'h001;
    localparam logic [13:0] csr_era   = 14'h006;
    localparam logic [13:0] csr_asid  = 14'h018;
    localparam logic [13:0] csr_save0 = 14'h030;

    localparam logic [1:0] tlb_srch = 2'b10; // ins[11:10]
    localparam logic [1:0] tlb_rd   = 2'b11;
    localparam logic [1:0] tlb_wr   = 2'b00;
    localparam logic [1:0] tlb_fill = 2'b01;
    localparam int ins_invtlb_bit = 16;      // set only in the invtlb encoding
endpackage

`default_nettype wire

/* rtl/priv_pkg.sv */
`default_nettype none

package priv_pkg;
    localparam int csr_num_w = 14;
    localparam int data_w    = 32;
    localparam int inv_op_w  = 5;
    localparam int inv_va_w  = 19; // vppn part of rk

    typedef enum logic [3:0] {
        op_none,
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_cacop_i,
        op_cacop_d,
        op_ertn,
        op_idle,
        op_tlbsrch,
        op_tlbrd,
        op_tlbwr,
        op_tlbfill,
        op_invtlb
    } priv_op_e;

    typedef enum logic [2:0] {
        st_init,
        st_csr,
        st_cacop_call,
        st_cacop_wait,
        st_ertn,
        st_idle_wait,
        st_idle,
        st_tlb_wait
    } exec_state_e;
endpackage

`default_nettype wire

/* rtl/priv_ifc.sv */
`default_nettype none

interface priv_op_if;
    import priv_pkg::*;

    priv_op_e             op;
    logic [csr_num_w-1:0] csr_num;
    logic [data_w-1:0]    wmask;    // rj_data on xchg, all ones otherwise
    logic [data_w-1:0]    wdata;
    logic [1:0]           cacop_type;
    logic [data_w-1:0]    vaddr;
    logic [inv_op_w-1:0]  inv_op;
    logic [data_w-1:0]    inv_asid;
    logic [inv_va_w-1:0]  inv_va;

    modport src (output op, csr_num, wmask, wdata, cacop_type, vaddr,
                 inv_op, inv_asid, inv_va);
    modport sink (input op, csr_num, wmask, wdata, cacop_type, vaddr,
                  inv_op, inv_asid, inv_va);
endinterface

interface csr_if;
    import priv_pkg::*;

    logic [csr_num_w-1:0] addr;
    logic                 wen;
    logic                 ertn;     // restore crmd from prmd
    logic [data_w-1:0]    wdata;
    logic [data_w-1:0]    wmask;
    logic [data_w-1:0]    rdata;
    logic [data_w-1:0]    era;

    modport master (output addr, wen, wdata, wmask, ertn, input rdata);
    modport slave (input addr, wen, wdata, wmask, ertn, output rdata, era);
endinterface

`default_nettype wire

/* rtl/priv_decode.sv */
`default_nettype none

module priv_decode (
    input  wire [31:0]                  ins,
    input  wire [la_isa_pkg::uop_w-1:0] pr_type,
    input  wire [priv_pkg::data_w-1:0]  rj_data,
    input  wire [priv_pkg::data_w-1:0]  rk_data,
    priv_op_if.src                      op_out
);
    import la_isa_pkg::*;
    import priv_pkg::*;

    logic [4:0]        rj;
    logic [data_w-1:0] imm_ext;

    assign rj      = ins[9:5];
    assign imm_ext = {{20{ins[21]}}, ins[21:10]}; // si12

    always_comb
    begin
        op_out.op = op_none;
        if (pr_type[uop_csr])
        begin
            if (rj == 5'd0)
                op_out.op = op_csrrd;
            else if (rj == 5'd1)
                op_out.op = op_csrwr;
            else
                op_out.op = op_csrxchg;
        end
        else if (pr_type[uop_cache])
        begin
            if (ins[2:0] == 3'd0)
                op_out.op = op_cacop_i;
            else if (ins[2:0] == 3'd1)
                op_out.op = op_cacop_d; // other targets unsupported
        end
        else if (pr_type[uop_ertn])
            op_out.op = op_ertn;
        else if (pr_type[uop_idle])
            op_out.op = op_idle;
        else if (pr_type[uop_tlb])
        begin
            // invtlb reuses bits 11:10 as rk, so test it first
            if (ins[ins_invtlb_bit])
                op_out.op = op_invtlb;
            else if (ins[11:10] == tlb_srch)
                op_out.op = op_tlbsrch;
            else if (ins[11:10] == tlb_rd)
                op_out.op = op_tlbrd;
            else if (ins[11:10] == tlb_wr)
                op_out.op = op_tlbwr;
            else if (ins[11:10] == tlb_fill)
                op_out.op = op_tlbfill;
        end
    end

    assign op_out.csr_num    = ins[23:10];
    assign op_out.wmask      = (rj > 5'd1) ? rj_data : '1;
    assign op_out.wdata      = rk_data;
    assign op_out.cacop_type = ins[4:3];
    assign op_out.vaddr      = rj_data + imm_ext;
    assign op_out.inv_op     = ins[4:0];
    assign op_out.inv_asid   = rj_data;
    assign op_out.inv_va     = rk_data[31:13];
endmodule

`default_nettype wire

/* rtl/priv_exec.sv */
`default_nettype none

module priv_exec (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           en,
    priv_op_if.sink                       op_in,
    csr_if.master                         csr,
    output logic [1:0]                    cacop_type,
    output logic [priv_pkg::data_w-1:0]   cacop_vaddr,
    output logic                          cacop_i_en,
    output logic                          cacop_d_en,
    input  wire                           cacop_i_ready,
    input  wire                           cacop_d_ready,
    input  wire                           cacop_i_done,
    input  wire                           cacop_d_done,
    input  wire                           i_idle,
    input  wire                           d_idle,
    output logic                          block_cache,
    output logic                          block_clock,
    output logic                          ertn_en,
    output logic                          tlbsrch_valid,
    output logic                          tlbrd_valid,
    output logic                          tlbwr_valid,
    output logic                          tlbfill_valid,
    output logic                          invtlb_valid,
    input  wire                           tlbsrch_ready,
    input  wire                           tlbrd_ready,
    input  wire                           tlbwr_ready,
    input  wire                           tlbfill_ready,
    input  wire                           invtlb_ready,
    output logic [priv_pkg::inv_op_w-1:0] invtlb_op,
    output logic [priv_pkg::data_w-1:0]   invtlb_asid,
    output logic [priv_pkg::inv_va_w-1:0] invtlb_va,
    output logic                          finish,
    output logic [priv_pkg::data_w-1:0]   csr_old,
    output logic                          is_csr
);
    import priv_pkg::*;

    exec_state_e          state;
    exec_state_e          next_state;
    priv_op_e             lat_op;
    logic [csr_num_w-1:0] lat_csr_num;
    logic [data_w-1:0]    lat_wmask;
    logic [data_w-1:0]    lat_wdata;
    logic [inv_op_w-1:0]  lat_inv_op;
    logic [data_w-1:0]    lat_inv_asid;
    logic [inv_va_w-1:0]  lat_inv_va;
    logic                 start;
    logic                 accept;
    logic                 cache_ready;
    logic                 cache_done;
    logic                 tlb_ready;
    logic                 resp_q;   // cache done or tlb ready seen last cycle

    assign start       = en && state == st_init;
    assign accept      = start && op_in.op != op_none;
    assign cache_ready = (lat_op == op_cacop_i) ? cacop_i_ready : cacop_d_ready;
    assign cache_done  = (lat_op == op_cacop_i) ? cacop_i_done : cacop_d_done;

    always_comb
    begin
        case (lat_op)
            op_tlbsrch: tlb_ready = tlbsrch_ready;
            op_tlbrd:   tlb_ready = tlbrd_ready;
            op_tlbwr:   tlb_ready = tlbwr_ready;
            op_tlbfill: tlb_ready = tlbfill_ready;
            op_invtlb:  tlb_ready = invtlb_ready;
            default:    tlb_ready = 1'b0;
        endcase
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_init:
                if (accept)
                begin
                    case (op_in.op)
                        op_csrrd, op_csrwr, op_csrxchg: next_state = st_csr;
                        op_cacop_i, op_cacop_d:         next_state = st_cacop_call;
                        op_ertn:                        next_state = st_ertn;
                        op_idle:                        next_state = st_idle_wait;
                        default:                        next_state = st_tlb_wait;
                    endcase
                end
            st_cacop_call: if (cache_ready) next_state = st_cacop_wait;
            st_cacop_wait: if (cache_done) next_state = st_init;
            st_idle_wait:  if (i_idle && d_idle) next_state = st_idle;
            st_tlb_wait:   if (tlb_ready) next_state = st_init;
            default:       next_state = st_init; // csr, ertn, idle take one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= st_init;
            lat_op <= op_none;
            resp_q <= 1'b0;
        end
        else
        begin
            state  <= next_state;
            resp_q <= (state == st_cacop_wait && cache_done) ||
                      (state == st_tlb_wait && tlb_ready);
            if (accept)
                lat_op <= op_in.op;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            lat_csr_num  <= op_in.csr_num;
            lat_wmask    <= op_in.wmask;
            lat_wdata    <= op_in.wdata;
            lat_inv_op   <= op_in.inv_op;
            lat_inv_asid <= op_in.inv_asid;
            lat_inv_va   <= op_in.inv_va;
            cacop_type   <= op_in.cacop_type;
            cacop_vaddr  <= op_in.vaddr;
            csr_old      <= csr.rdata; // old value, read in the en cycle
        end
    end

    assign csr.addr  = (state == st_init) ? op_in.csr_num : lat_csr_num;
    assign csr.wen   = state == st_csr && lat_op != op_csrrd;
    assign csr.wdata = lat_wdata;
    assign csr.wmask = lat_wmask;
    assign csr.ertn  = start && op_in.op == op_ertn;

    assign cacop_i_en  = state == st_cacop_call && lat_op == op_cacop_i;
    assign cacop_d_en  = state == st_cacop_call && lat_op == op_cacop_d;
    assign block_cache = (start && op_in.op == op_idle) || state == st_idle_wait ||
                         state == st_idle;
    assign block_clock = state == st_idle;
    assign ertn_en     = state == st_ertn;

    assign tlbsrch_valid = start && op_in.op == op_tlbsrch;
    assign tlbrd_valid   = start && op_in.op == op_tlbrd;
    assign tlbwr_valid   = start && op_in.op == op_tlbwr;
    assign tlbfill_valid = start && op_in.op == op_tlbfill;
    assign invtlb_valid  = start && op_in.op == op_invtlb;

    // live fields alongside the valid pulse, held copy afterwards
    assign invtlb_op   = (state == st_init) ? op_in.inv_op : lat_inv_op;
    assign invtlb_asid = (state == st_init) ? op_in.inv_asid : lat_inv_asid;
    assign invtlb_va   = (state == st_init) ? op_in.inv_va : lat_inv_va;

    assign finish = state == st_csr || state == st_ertn || state == st_idle || resp_q;
    assign is_csr = state == st_csr;
endmodule

`default_nettype wire

/* rtl/csr_file.sv */
`default_nettype none

module csr_file (
    input wire   clk,
    input wire   rstn,
    csr_if.slave csr
);
    import la_isa_pkg::*;

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] era;
    logic [31:0] asid;
    logic [31:0] save0;
    logic [31:0] old;
    logic [31:0] merged;

    always_comb
    begin
        case (csr.addr)
            csr_crmd:  old = crmd;
            csr_prmd:  old = prmd;
            csr_era:   old = era;
            csr_asid:  old = asid;
            csr_save0: old = save0;
            default:   old = '0;   // not implemented
        endcase
    end

    assign merged    = (old & ~csr.wmask) | (csr.wdata & csr.wmask);
    assign csr.rdata = old;
    assign csr.era   = era;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            crmd  <= '0;
            prmd  <= '0;
            era   <= '0;
            asid  <= '0;
            save0 <= '0;
        end
        else if (csr.ertn)
            crmd[2:0] <= prmd[2:0]; // plv and ie from pplv, pie
        else if (csr.wen)
        begin
            case (csr.addr)
                csr_crmd:  crmd  <= merged;
                csr_prmd:  prmd  <= merged;
                csr_era:   era   <= merged;
                csr_asid:  asid  <= merged;
                csr_save0: save0 <= merged;
                default: ;
            endcase
        end
    end
endmodule

`default_nettype wire

/* rtl/priv_result.sv */
`default_nettype none

module priv_result (
    input  wire         clk,
    input  wire         rstn,
    input  wire         finish,
    input  wire         is_csr,
    input  wire  [31:0] csr_old,
    output logic        done,
    output logic        rd_we,
    output logic [31:0] rd_data
);
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            done  <= 1'b0;
            rd_we <= 1'b0;
        end
        else
        begin
            done  <= finish;
            rd_we <= finish && is_csr;  // only csr ops write rd
        end
    end

    always_ff @(posedge clk)
    begin
        if (finish && is_csr)
            rd_data <= csr_old;
    end
endmodule

`default_nettype wire

/* rtl/priv_unit.sv */
`default_nettype none

module priv_unit (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           en,
    input  wire  [31:0]                   ins,
    input  wire  [la_isa_pkg::uop_w-1:0]  pr_type,
    input  wire  [priv_pkg::data_w-1:0]   rj_data,
    input  wire  [priv_pkg::data_w-1:0]   rk_data,
    output logic [1:0]                    cacop_type,
    output logic [priv_pkg::data_w-1:0]   cacop_vaddr,
    output logic                          cacop_i_en,
    output logic                          cacop_d_en,
    input  wire                           cacop_i_ready,
    input  wire                           cacop_d_ready,
    input  wire                           cacop_i_done,
    input  wire                           cacop_d_done,
    input  wire                           i_idle,
    input  wire                           d_idle,
    output logic                          block_cache,
    output logic                          block_clock,
    output logic                          ertn_en,
    output logic [priv_pkg::data_w-1:0]   ertn_pc,
    output logic                          tlbsrch_valid,
    output logic                          tlbrd_valid,
    output logic                          tlbwr_valid,
    output logic                          tlbfill_valid,
    output logic                          invtlb_valid,
    input  wire                           tlbsrch_ready,
    input  wire                           tlbrd_ready,
    input  wire                           tlbwr_ready,
    input  wire                           tlbfill_ready,
    input  wire                           invtlb_ready,
    output logic [priv_pkg::inv_op_w-1:0] invtlb_op,
    output logic [priv_pkg::data_w-1:0]   invtlb_asid,
    output logic [priv_pkg::inv_va_w-1:0] invtlb_va,
    output logic                          done,
    output logic                          rd_we,
    output logic [priv_pkg::data_w-1:0]   rd_data
);
    import priv_pkg::*;

    logic              finish;
    logic              is_csr;
    logic [data_w-1:0] csr_old;

    priv_op_if op_bus ();
    csr_if     csr_bus ();

    priv_decode u_decode (
        .ins     (ins),
        .pr_type (pr_type),
        .rj_data (rj_data),
        .rk_data (rk_data),
        .op_out  (op_bus.src)
    );

    priv_exec u_exec (
        .clk           (clk),
        .rstn          (rstn),
        .en            (en),
        .op_in         (op_bus.sink),
        .csr           (csr_bus.master),
        .cacop_type    (cacop_type),
        .cacop_vaddr   (cacop_vaddr),
        .cacop_i_en    (cacop_i_en),
        .cacop_d_en    (cacop_d_en),
        .cacop_i_ready (cacop_i_ready),
        .cacop_d_ready (cacop_d_ready),
        .cacop_i_done  (cacop_i_done),
        .cacop_d_done  (cacop_d_done),
        .i_idle        (i_idle),
        .d_idle        (d_idle),
        .block_cache   (block_cache),
        .block_clock   (block_clock),
        .ertn_en       (ertn_en),
        .tlbsrch_valid (tlbsrch_valid),
        .tlbrd_valid   (tlbrd_valid),
        .tlbwr_valid   (tlbwr_valid),
        .tlbfill_valid (tlbfill_valid),
        .invtlb_valid  (invtlb_valid),
        .tlbsrch_ready (tlbsrch_ready),
        .tlbrd_ready   (tlbrd_ready),
        .tlbwr_ready   (tlbwr_ready),
        .tlbfill_ready (tlbfill_ready),
        .invtlb_ready  (invtlb_ready),
        .invtlb_op     (invtlb_op),
        .invtlb_asid   (invtlb_asid),
        .invtlb_va     (invtlb_va),
        .finish        (finish),
        .csr_old       (csr_old),
        .is_csr        (is_csr)
    );

    csr_file u_csr_file (
        .clk  (clk),
        .rstn (rstn),
        .csr  (csr_bus.slave)
    );

    assign ertn_pc = csr_bus.era; // return address straight from era

    priv_result u_result (
        .clk     (clk),
        .rstn    (rstn),
        .finish  (finish),
        .is_csr  (is_csr),
        .csr_old (csr_old),
        .done    (done),
        .rd_we   (rd_we),
        .rd_data (rd_data)
    );
endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial
    begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
    end
endmodule

`default_nettype wire

/* dv/priv_unit_tb.sv */
`default_nettype none

module priv_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import la_isa_pkg::*;
    import priv_pkg::*;

    logic clk, rstn, en, cacop_i_ready, cacop_d_ready, cacop_i_done, cacop_d_done;
    logic i_idle, d_idle, block_cache, block_clock, ertn_en, cacop_i_en, cacop_d_en;
    logic tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid;
    logic tlbsrch_ready, tlbrd_ready, tlbwr_ready, tlbfill_ready, invtlb_ready;
    logic done, rd_we;
    logic [31:0] ins, rj_data, rk_data, cacop_vaddr, ertn_pc, invtlb_asid, rd_data;
    logic [uop_w-1:0] pr_type;
    logic [1:0] cacop_type;
    logic [inv_op_w-1:0] invtlb_op;
    logic [inv_va_w-1:0] invtlb_va;
    logic [31:0] model [0:16383];   // reference csr values
    logic [31:0] rng = 32'd93972;
    int cyc = 0;

    clk_gen u_clk_gen (.clk(clk), .rstn(rstn));
    priv_unit u_priv_unit (.*);

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string msg);
        $display("timed out: %s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_that(input logic ok, input string msg);
        assert (ok) else report_mismatch(msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic issue(input logic [31:0] i, input int uop, input logic [31:0] a,
                         input logic [31:0] b);
        @(posedge clk);
        en      <= 1'b1;
        ins     <= i;
        pr_type <= '0;
        pr_type[uop] <= 1'b1;
        rj_data <= a;
        rk_data <= b;
        @(negedge clk);
    endtask

    task automatic wait_done(output int at);
        int n;
        n = 0;
        while (!done)
        begin
            if (n == 200)
                report_timeout("done never came back from the DUT");
            n++;
            next_cycle();
        end
        at = cyc;
    endtask

    task automatic csr_op(input logic [13:0] num, input logic [4:0] rjf,
                          input logic [31:0] a, input logic [31:0] b);
        logic [31:0] old;
        logic [31:0] mask;
        old  = model[num];
        mask = (rjf > 5'd1) ? a : 32'hffff_ffff;   // xchg masks with rj
        if (rjf != 5'd0)
            model[num] = (old & ~mask) | (b & mask);
        issue({8'd0, num, rjf, 5'd4}, uop_csr, a, b);
        check_that(!done && !rd_we, "csr done in cycle 0");
        next_cycle();
        check_that(!done && !rd_we, "csr done in cycle 1");
        next_cycle();
        check_that(done && rd_we, "csr done or rd_we missing in cycle 2");
        check_that(rd_data == old, $sformatf("csr %h rd_data %h, expected %h",
                   num, rd_data, old));
    endtask

    function automatic logic cache_en_ok(input logic [2:0] target);
        if (target == 3'd0)
            return cacop_i_en && !cacop_d_en;
        else
            return cacop_d_en && !cacop_i_en;
    endfunction

    task automatic cacop_op(input logic [2:0] target, input logic [1:0] kind,
                            input logic [11:0] imm, input logic [31:0] a);
        logic [31:0] va;
        int d;
        int t;
        int at;
        va = a + {{20{imm[11]}}, imm};
        issue({10'd0, imm, 5'd7, kind, target}, uop_cache, a, 32'd0);
        next_cycle();
        d = xorshift() % 32'd4;
        for (int k = 0; k < d; k++)
        begin
            check_that(cache_en_ok(target), "cache enable wrong while ready low");
            next_cycle();
        end
        @(posedge clk);
        if (target == 3'd0)
            cacop_i_ready <= 1'b1;
        else
            cacop_d_ready <= 1'b1;
        @(negedge clk);
        check_that(cache_en_ok(target), "cache enable wrong in ready cycle");
        check_that(cacop_vaddr == va, $sformatf("cacop_vaddr %h, expected %h",
                   cacop_vaddr, va));
        check_that(cacop_type == kind, "cacop_type wrong");
        @(posedge clk);
        cacop_i_ready <= 1'b0;
        cacop_d_ready <= 1'b0;
        @(negedge clk);
        check_that(!cacop_i_en && !cacop_d_en, "cache enable still high after ready");
        d = xorshift() % 32'd5;
        for (int k = 0; k < d; k++)
        begin
            check_that(!done, "done before cache done");
            next_cycle();
        end
        @(posedge clk);
        if (target == 3'd0)
            cacop_i_done <= 1'b1;
        else
            cacop_d_done <= 1'b1;
        @(negedge clk);
        t = cyc;
        @(posedge clk);
        cacop_i_done <= 1'b0;
        cacop_d_done <= 1'b0;
        @(negedge clk);
        wait_done(at);
        check_that(at == t + 2, $sformatf("cacop done %0d cycles after cache done", at - t));
        check_that(!rd_we, "rd_we high for cacop");
    endtask

    task automatic tlb_op(input logic [31:0] i, input int which, input logic [31:0] a,
                          input logic [31:0] b);
        int d;
        int t;
        int at;
        issue(i, uop_tlb, a, b);
        check_that({tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid}
                   == (5'b10000 >> which), $sformatf("wrong tlb valid for command %0d", which));
        if (which == 4)
            check_that(invtlb_op == i[4:0] && invtlb_asid == a && invtlb_va == b[31:13],
                       "invtlb fields wrong");
        next_cycle();
        check_that({tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid}
                   == 5'b0, "tlb valid longer than one cycle");
        d = xorshift() % 32'd6;
        repeat (d) next_cycle();
        @(posedge clk);
        case (which)
            0: tlbsrch_ready <= 1'b1;
            1: tlbrd_ready   <= 1'b1;
            2: tlbwr_ready   <= 1'b1;
            3: tlbfill_ready <= 1'b1;
            default: invtlb_ready <= 1'b1;
        endcase
        @(negedge clk);
        t = cyc;
        @(posedge clk);
        {tlbsrch_ready, tlbrd_ready, tlbwr_ready, tlbfill_ready, invtlb_ready} <= 5'b0;
        @(negedge clk);
        wait_done(at);
        check_that(at == t + 2, $sformatf("tlb done %0d cycles after ready", at - t));
    endtask

    task automatic idle_op();
        int n;
        int di;
        int dd;
        di = xorshift() % 32'd6;
        dd = xorshift() % 32'd6;
        issue(32'h0648_8000, uop_idle, 32'd0, 32'd0);
        n = 0;
        while (!(i_idle && d_idle))
        begin
            check_that(block_cache && !block_clock && !done, "block state wrong in idle wait");
            if (n == 100)
                report_timeout("idle inputs never both high");
            @(posedge clk);
            en <= 1'b0;
            if (n >= di)
                i_idle <= 1'b1;
            if (n >= dd)
                d_idle <= 1'b1;
            @(negedge clk);
            n++;
        end
        check_that(block_cache && !block_clock, "block_cache dropped early");
        next_cycle();
        check_that(block_clock && block_cache && !done, "block_clock cycle wrong");
        @(posedge clk);
        i_idle <= 1'b0;
        d_idle <= 1'b0;
        @(negedge clk);
        check_that(!block_clock && !block_cache && done && !rd_we, "idle end wrong");
    endtask

    initial
    begin
        int n;
        en <= 1'b0;
        ins <= '0;
        pr_type <= '0;
        rj_data <= '0;
        rk_data <= '0;
        {cacop_i_ready, cacop_d_ready, cacop_i_done, cacop_d_done} <= 4'b0;
        {i_idle, d_idle} <= 2'b0;
        {tlbsrch_ready, tlbrd_ready, tlbwr_ready, tlbfill_ready, invtlb_ready} <= 5'b0;
        for (int k = 0; k < 16384; k++)
            model[k] = 32'd0;
        n = 0;
        while (rstn !== 1'b1)
        begin
            if (n == 50)
                report_timeout("reset never released");
            n++;
            @(negedge clk);
        end
        @(negedge clk);
        check_that({done, rd_we, cacop_i_en, cacop_d_en, ertn_en, block_cache, block_clock,
                    tlbsrch_valid, tlbrd_valid, tlbwr_valid, tlbfill_valid, invtlb_valid}
                   == 12'b0, "control outputs not low after reset");

        csr_op(csr_save0, 5'd1, 32'd0, xorshift());
        csr_op(csr_save0, 5'd0, 32'd0, 32'd0);
        csr_op(csr_asid, 5'd1, 32'd0, xorshift());
        csr_op(csr_asid, 5'd3, xorshift(), xorshift());
        csr_op(csr_save0, 5'd7, xorshift(), xorshift());
        csr_op(csr_asid, 5'd0, 32'd0, 32'd0);
        csr_op(csr_save0, 5'd0, 32'd0, 32'd0);

        csr_op(csr_prmd, 5'd1, 32'd0, 32'h0000_0006);
        csr_op(csr_era, 5'd1, 32'd0, 32'h1c00_1234);
        csr_op(csr_crmd, 5'd1, 32'd0, 32'h0000_0011);
        issue(32'h0648_3800, uop_ertn, 32'd0, 32'd0);
        next_cycle();
        check_that(ertn_en && ertn_pc == model[csr_era],
                   $sformatf("ertn_pc %h, expected %h", ertn_pc, model[csr_era]));
        model[csr_crmd][2:0] = model[csr_prmd][2:0];
        next_cycle();
        check_that(done && !rd_we && !ertn_en, "ertn done wrong");
        csr_op(csr_crmd, 5'd0, 32'd0, 32'd0);

        cacop_op(3'd0, 2'd1, 12'h7f0, xorshift());
        cacop_op(3'd1, 2'd2, 12'h804, xorshift());  // negative offset
        cacop_op(3'd1, 2'd0, 12'h010, xorshift());

        tlb_op(32'h0648_2800, 0, 32'd0, 32'd0);
        tlb_op(32'h0648_2c00, 1, 32'd0, 32'd0);
        tlb_op(32'h0648_3000, 2, 32'd0, 32'd0);
        tlb_op(32'h0648_3400, 3, 32'd0, 32'd0);
        tlb_op(32'h0649_88a5, 4, xorshift(), xorshift());

        idle_op();
        idle_op();

        issue({10'd0, 12'h020, 5'd7, 2'd0, 3'd2}, uop_cache, 32'd0, 32'd0);
        repeat (30)
        begin
            check_that(!done && !cacop_i_en && !cacop_d_en, "unsupported cacop answered");
            next_cycle();
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

`default_nettype wire

/* src.f */
rtl/la_isa_pkg.sv
rtl/priv_pkg.sv
rtl/priv_ifc.sv
rtl/priv_decode.sv
rtl/priv_exec.sv
rtl/csr_file.sv
rtl/priv_result.sv
rtl/priv_unit.sv
dv/clk_gen.sv
dv/priv_unit_tb.sv

/* Makefile */
TOP = priv_unit_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
